//--- dv/opdecoder_assert.sv
`timescale 1ns/10ps

module opdecoder_assert (
	input logic clk,
	input logic rst_n,
	input logic nmi_n,
	input logic [opdecoder_pkg::ENTRY_W-1:0] step0_a,
	input logic [opdecoder_pkg::ENTRY_W-1:0] step1_a,
	input logic [opdecoder_pkg::ENTRY_W-1:0] int_a,
	input opdecoder_pkg::reg_sel_t register,
	input opdecoder_pkg::alu_op_t alu_op
);
	import opdecoder_pkg::*;

	int failures = 0;

	// entries are step codes times two
	even_entries: assert property (@(posedge clk) disable iff (!rst_n)
		!step0_a[0] && !step1_a[0] && !int_a[0])
		else begin
			$error("odd microcode entry address");
			failures++;
		end

	nmi_entry: assert property (@(posedge clk) disable iff (!rst_n)
		!nmi_n |=> int_a == INMI * 2)
		else begin
			$error("int_a is not the nmi entry after nmi_n low");
			failures++;
		end

	reset_values: assert property (@(posedge clk)
		!rst_n |=> step0_a == NOP * 2 && step1_a == NOP * 2 && int_a == IOPC * 2
			&& register == REGACC && alu_op == ALU_LOAD)
		else begin
			$error("outputs not at reset values after rst_n low");
			failures++;
		end

endmodule

//--- dv/opdecoder_model.svh
`ifndef OPDECODER_MODEL_SVH
`define OPDECODER_MODEL_SVH

////////////////////////////////////////////////////////////
// flat opcode table
////////////////////////////////////////////////////////////

function automatic decode_t expected_decode(input logic [7:0] op, input logic br);
	logic [STEP_W-1:0] s0;
	logic [STEP_W-1:0] s1;
	reg_sel_t rs;
	alu_op_t alu;
	s0 = NOP;
	s1 = NOP;
	rs = REGACC;
	alu = ALU_LOAD;

	// first step
	case (op)
		8'h01, 8'h21, 8'h41, 8'h61, 8'h81, 8'hA1, 8'hC1, 8'hE1: s0 = AINX;
		8'h05, 8'h25, 8'h45, 8'h65, 8'h85, 8'hA5, 8'hC5, 8'hE5,
		8'h06, 8'h26, 8'h46, 8'h66, 8'h86, 8'hA6, 8'hC6, 8'hE6,
		8'h24, 8'h84, 8'hA4, 8'hC4, 8'hE4: s0 = AZEP;
		8'h09, 8'h29, 8'h49, 8'h69, 8'hE9: s0 = ALUOPI;
		8'hA9, 8'hA2, 8'hA0: s0 = ALULOADI;
		8'hC9, 8'hC0, 8'hE0: s0 = CMPI;
		8'h0D, 8'h2D, 8'h4D, 8'h6D, 8'h8D, 8'hAD, 8'hCD, 8'hED,
		8'h0E, 8'h2E, 8'h4E, 8'h6E, 8'h8E, 8'hAE, 8'hCE, 8'hEE,
		8'h2C, 8'h8C, 8'hAC, 8'hCC, 8'hEC: s0 = AABS;
		8'h11, 8'h31, 8'h51, 8'h71, 8'h91, 8'hB1, 8'hD1, 8'hF1: s0 = AINY;
		8'h15, 8'h35, 8'h55, 8'h75, 8'h95, 8'hB5, 8'hD5, 8'hF5,
		8'h16, 8'h36, 8'h56, 8'h76, 8'hD6, 8'hF6, 8'h94, 8'hB4: s0 = AZPX;
		8'h96, 8'hB6: s0 = AZPY;
		8'h19, 8'h39, 8'h59, 8'h79, 8'h99, 8'hB9, 8'hD9, 8'hF9,
		8'hBE: s0 = AABY;
		8'h1D, 8'h3D, 8'h5D, 8'h7D, 8'h9D, 8'hBD, 8'hDD, 8'hFD,
		8'h1E, 8'h3E, 8'h5E, 8'h7E, 8'hDE, 8'hFE, 8'hBC: s0 = AABX;
		8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0: s0 = WBR;
		8'h0A, 8'h2A, 8'h4A, 8'h6A, 8'hCA, 8'h88, 8'hC8, 8'hE8: s0 = ALUOP;
		8'h00: s0 = BRK;
		8'h40: s0 = RTI;
		8'h60: s0 = RTS;
		8'h4C: s0 = JMPA;
		8'h6C: s0 = JMPI;
		8'h20: s0 = AABSNINC;
		8'h08: s0 = PHP;
		8'h28: s0 = PLP;
		8'h48: s0 = PHA;
		8'h68: s0 = PLA;
		8'h18: s0 = CLC;
		8'h38: s0 = SEC;
		8'h58: s0 = CLI;
		8'h78: s0 = SEI;
		8'hB8: s0 = CLV;
		8'hD8: s0 = CLD;
		8'hF8: s0 = SED;
		8'h8A: s0 = TXA;
		8'h98: s0 = TYA;
		8'h9A: s0 = TXS;
		8'hA8: s0 = TAY;
		8'hAA: s0 = TAX;
		8'hBA: s0 = TSX;
		default: s0 = NOP;
	endcase

	// second step, register and alu
	case (op)
		8'h01, 8'h05, 8'h0D, 8'h11, 8'h15, 8'h19, 8'h1D:
			{s1, rs, alu} = {ALUOP, REGACC, ALU_OR};
		8'h21, 8'h25, 8'h2D, 8'h31, 8'h35, 8'h39, 8'h3D:
			{s1, rs, alu} = {ALUOP, REGACC, ALU_AND};
		8'h41, 8'h45, 8'h4D, 8'h51, 8'h55, 8'h59, 8'h5D:
			{s1, rs, alu} = {ALUOP, REGACC, ALU_EOR};
		8'h61, 8'h65, 8'h6D, 8'h71, 8'h75, 8'h79, 8'h7D:
			{s1, rs, alu} = {ALUOP, REGACC, ALU_ADC};
		8'h81, 8'h85, 8'h8D, 8'h91, 8'h95, 8'h99, 8'h9D:
			{s1, rs, alu} = {ALUMEM, REGACC, ALU_LOAD};
		8'hA1, 8'hA5, 8'hAD, 8'hB1, 8'hB5, 8'hB9, 8'hBD:
			{s1, rs, alu} = {ALULOAD, REGACC, ALU_LD};
		8'hC1, 8'hC5, 8'hCD, 8'hD1, 8'hD5, 8'hD9, 8'hDD:
			{s1, rs, alu} = {CMP, REGACC, ALU_LOAD};
		8'hE1, 8'hE5, 8'hED, 8'hF1, 8'hF5, 8'hF9, 8'hFD:
			{s1, rs, alu} = {ALUOP, REGACC, ALU_SBC};
		// immediates finish in the first step
		8'h09: alu = ALU_OR;
		8'h29: alu = ALU_AND;
		8'h49: alu = ALU_EOR;
		8'h69: alu = ALU_ADC;
		8'hA9: alu = ALU_LD;
		8'hE9: alu = ALU_SBC;
		8'h06, 8'h0E, 8'h16, 8'h1E: {s1, rs, alu} = {ALUMEM, REGDIN, ALU_ASL};
		8'h26, 8'h2E, 8'h36, 8'h3E: {s1, rs, alu} = {ALUMEM, REGDIN, ALU_ROL};
		8'h46, 8'h4E, 8'h56, 8'h5E: {s1, rs, alu} = {ALUMEM, REGDIN, ALU_LSR};
		// ror zp keeps the accumulator
		8'h66: {s1, rs, alu} = {ALUMEM, REGACC, ALU_ROR};
		8'h6E, 8'h76, 8'h7E: {s1, rs, alu} = {ALUMEM, REGDIN, ALU_ROR};
		8'hC6, 8'hCE, 8'hD6, 8'hDE: {s1, rs, alu} = {ALUMEM, REGDIN, ALU_DEC};
		8'hE6, 8'hEE, 8'hF6, 8'hFE: {s1, rs, alu} = {ALUMEM, REGDIN, ALU_INC};
		8'h0A: alu = ALU_ASL;
		8'h2A: alu = ALU_ROL;
		8'h4A: alu = ALU_LSR;
		8'h6A: alu = ALU_ROR;
		8'hCA: {rs, alu} = {REGX, ALU_DEC};
		8'h86, 8'h8E, 8'h96: {s1, rs} = {ALUMEM, REGX};
		8'hA6, 8'hAE, 8'hB6, 8'hBE: {s1, rs, alu} = {ALULOAD, REGX, ALU_LD};
		8'hA2: {rs, alu} = {REGX, ALU_LD};
		8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hB0, 8'hD0, 8'hF0:
			s1 = br ? BRA : NBR;
		8'h20: s1 = JSR;
		8'h24, 8'h2C: s1 = BIT;
		8'hA0: {rs, alu} = {REGY, ALU_LD};
		8'hC0: rs = REGY;
		8'hE0: rs = REGX;
		8'h88: {rs, alu} = {REGY, ALU_DEC};
		8'hC8: {rs, alu} = {REGY, ALU_INC};
		8'hE8: {rs, alu} = {REGX, ALU_INC};
		8'h84, 8'h8C, 8'h94: {s1, rs} = {ALUMEM, REGY};
		8'hA4, 8'hAC, 8'hB4, 8'hBC: {s1, rs, alu} = {ALULOAD, REGY, ALU_LD};
		8'hC4, 8'hCC: {s1, rs} = {CMP, REGY};
		8'hE4, 8'hEC: {s1, rs} = {CMP, REGX};
		default: s1 = NOP;
	endcase

	return '{steps: '{step0: s0, step1: s1}, reg_sel: rs, alu_op: alu};
endfunction

// nmi wins, irq only while enabled
function automatic logic [STEP_W-1:0] interrupt_step(
	input logic nmi_low_n,
	input logic irq_low_n,
	input logic irq_enable
);
	if (!nmi_low_n)
		return INMI;
	else if (!irq_low_n && irq_enable)
		return IIRQ;
	else
		return IOPC;
endfunction

`endif

//--- dv/tb_opdecoder.sv
`timescale 1ns/10ps

module tb_opdecoder;
	import opdecoder_pkg::*;

	localparam int SWEEP_VECTORS = 512;
	localparam int RANDOM_VECTORS = 2000;
	localparam int INT_VECTORS = 256;
	localparam int MIDRST_VECTORS = 200;
	localparam int TOTAL_VECTORS = 5 + SWEEP_VECTORS + RANDOM_VECTORS + INT_VECTORS
		+ MIDRST_VECTORS;

	logic clk;
	logic rst_n;
	opcode_u ireg;
	logic branch;
	logic irqen;
	logic irq_n;
	logic nmi_n;
	logic [ENTRY_W-1:0] step0_a;
	logic [ENTRY_W-1:0] step1_a;
	logic [ENTRY_W-1:0] int_a;
	reg_sel_t register;
	alu_op_t alu_op;

	// expected outputs for the inputs of the last edge
	logic [ENTRY_W-1:0] exp_step0_a;
	logic [ENTRY_W-1:0] exp_step1_a;
	logic [ENTRY_W-1:0] exp_int_a;
	reg_sel_t exp_register;
	alu_op_t exp_alu_op;
	logic primed;

	integer seed;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int test_start_errors;

	`include "opdecoder_model.svh"

	opdecoder opdecoder_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.ireg     (ireg),
		.branch   (branch),
		.irqen    (irqen),
		.irq_n    (irq_n),
		.nmi_n    (nmi_n),
		.step0_a  (step0_a),
		.step1_a  (step1_a),
		.int_a    (int_a),
		.register (register),
		.alu_op   (alu_op)
	);

	bind opdecoder opdecoder_assert opdecoder_assert_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.nmi_n    (nmi_n),
		.step0_a  (step0_a),
		.step1_a  (step1_a),
		.int_a    (int_a),
		.register (register),
		.alu_op   (alu_op)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	function automatic logic [ENTRY_W-1:0] entry_of(input logic [STEP_W-1:0] step);
		logic [ENTRY_W-1:0] wide;
		wide = step;
		return wide * 2;
	endfunction

	////////////////////////////////////////////////////////////
	// model and compare
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		decode_t d;
		d = expected_decode(ireg.raw, branch);
		if (!rst_n) begin
			exp_step0_a <= entry_of(NOP);
			exp_step1_a <= entry_of(NOP);
			exp_int_a <= entry_of(IOPC);
			exp_register <= REGACC;
			exp_alu_op <= ALU_LOAD;
		end else begin
			exp_step0_a <= entry_of(d.steps.step0);
			exp_step1_a <= entry_of(d.steps.step1);
			exp_int_a <= entry_of(interrupt_step(nmi_n, irq_n, irqen));
			exp_register <= d.reg_sel;
			exp_alu_op <= d.alu_op;
		end
		primed <= 1'b1;
	end

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s at %0t: got %0h, expected %0h", name, $time, got, exp);
		end
	endtask

	// outputs settle after the rising edge
	always @(negedge clk) begin
		if (primed) begin
			check("step0_a", step0_a, exp_step0_a);
			check("step1_a", step1_a, exp_step1_a);
			check("int_a", int_a, exp_int_a);
			check("register", register, exp_register);
			check("alu_op", alu_op, exp_alu_op);
		end
	end

	task automatic drive(input logic [7:0] op, input logic br, input logic en,
		input logic irqn, input logic nmin);
		@(posedge clk);
		ireg.raw <= op;
		branch <= br;
		irqen <= en;
		irq_n <= irqn;
		nmi_n <= nmin;
	endtask

	task automatic drive_random();
		logic [31:0] r;
		r = $random(seed);
		drive(r[7:0], r[8], r[9], r[10], r[11]);
	endtask

	task automatic start_test();
		test_start_errors = errors;
	endtask

	// let the last vector reach the compare before counting
	task automatic report_test(input string name);
		@(posedge clk);
		@(negedge clk);
		#1;
		tests_run++;
		if (errors != test_start_errors) begin
			tests_failed++;
			$display("test %s: FAIL with %0d errors", name, errors - test_start_errors);
		end else begin
			$display("test %s: pass", name);
		end
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		seed = 17887;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		primed = 1'b0;
		rst_n = 1'b0;
		ireg = '0;
		branch = 1'b0;
		irqen = 1'b0;
		irq_n = 1'b1;
		nmi_n = 1'b1;

		// random inputs must not leak through reset
		start_test();
		repeat (4) drive_random();
		drive(8'hEA, 1'b0, 1'b0, 1'b1, 1'b1);
		rst_n <= 1'b1;
		report_test("reset");

		start_test();
		for (int br = 0; br < 2; br++) begin
			for (int op = 0; op < 256; op++)
				drive(8'(op), br[0], 1'b0, 1'b1, 1'b1);
		end
		report_test("opcode sweep");

		start_test();
		repeat (RANDOM_VECTORS) drive_random();
		report_test("random stream");

		start_test();
		for (int i = 0; i < INT_VECTORS; i++) begin
			r = $random(seed);
			drive(r[18:11], r[19], r[8], r[9], r[10]);
		end
		report_test("interrupt priority");

		start_test();
		for (int i = 0; i < MIDRST_VECTORS; i++) begin
			drive_random();
			rst_n <= !(i >= 100 && i < 103);
		end
		report_test("mid-run reset");

		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, checks, errors, opdecoder_i.opdecoder_assert_i.failures);
		if (errors == 0 && opdecoder_i.opdecoder_assert_i.failures == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#(2 * TOTAL_VECTORS * 10);
		$display("watchdog expired after %0d ns before the tests finished",
			2 * TOTAL_VECTORS * 10);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- hdl/entry_register.sv
`timescale 1ns/10ps

module entry_register (
	input logic clk,
	input logic rst_n,
	input opdecoder_pkg::decode_t dec,
	input logic irq_n,
	input logic nmi_n,
	input logic irqen,
	output logic [opdecoder_pkg::ENTRY_W-1:0] step0_a,
	output logic [opdecoder_pkg::ENTRY_W-1:0] step1_a,
	output logic [opdecoder_pkg::ENTRY_W-1:0] int_a,
	output opdecoder_pkg::reg_sel_t register,
	output opdecoder_pkg::alu_op_t alu_op
);
	import opdecoder_pkg::*;

	logic [STEP_W-1:0] int_step;

	// microcode entry is twice the step number
	function automatic logic [ENTRY_W-1:0] to_entry(input logic [STEP_W-1:0] step);
		return {step, 1'b0};
	endfunction

	// nmi first, then irq when enabled
	always_comb begin
		if (!nmi_n)
			int_step = INMI;
		else if (!irq_n && irqen)
			int_step = IIRQ;
		else
			int_step = IOPC;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			step0_a <= to_entry(NOP);
			step1_a <= to_entry(NOP);
			int_a <= to_entry(IOPC);
			register <= REGACC;
			alu_op <= ALU_LOAD;
		end else begin
			step0_a <= to_entry(dec.steps.step0);
			step1_a <= to_entry(dec.steps.step1);
			int_a <= to_entry(int_step);
			register <= dec.reg_sel;
			alu_op <= dec.alu_op;
		end
	end

endmodule

//--- hdl/mode_decoder.sv
`timescale 1ns/10ps

module mode_decoder (
	input opdecoder_pkg::opcode_u ireg,
	output logic [opdecoder_pkg::STEP_W-1:0] step0
);
	import opdecoder_pkg::*;

	logic [STEP_W-1:0] field_step;

	// bbb to addressing step for the memory forms
	function automatic logic [STEP_W-1:0] mem_mode(input logic [2:0] bbb);
		logic [STEP_W-1:0] mode;
		case (bbb)
			3'b000: mode = AINX;
			3'b001: mode = AZEP;
			3'b010: mode = ALUOPI;
			3'b011: mode = AABS;
			3'b100: mode = AINY;
			3'b101: mode = AZPX;
			3'b110: mode = AABY;
			default: mode = AABX;
		endcase
		return mode;
	endfunction

	////////////////////////////////////////////////////////////
	// regular groups
	////////////////////////////////////////////////////////////

	always_comb begin
		field_step = NOP;
		case (ireg.fld.cc)
			2'b01: begin
				field_step = mem_mode(ireg.fld.bbb);
				if (ireg.fld.bbb == 3'b010) begin
					if (ireg.fld.aaa == 3'b100)
						field_step = NOP;
					else if (ireg.fld.aaa == 3'b101)
						field_step = ALULOADI;
					else if (ireg.fld.aaa == 3'b110)
						field_step = CMPI;
				end
			end
			2'b10: begin
				case (ireg.fld.bbb)
					3'b000: begin
						if (ireg.fld.aaa == 3'b101)
							field_step = ALULOADI;
					end
					3'b001, 3'b011: field_step = mem_mode(ireg.fld.bbb);
					3'b101: begin
						// stx/ldx index with y
						if (ireg.fld.aaa[2:1] == 2'b10)
							field_step = AZPY;
						else
							field_step = AZPX;
					end
					3'b111: begin
						if (ireg.fld.aaa == 3'b101)
							field_step = AABY;
						else if (ireg.fld.aaa != 3'b100)
							field_step = AABX;
					end
					default: field_step = NOP;
				endcase
			end
			2'b00: begin
				case (ireg.fld.bbb)
					3'b000: begin
						if (ireg.fld.aaa == 3'b101)
							field_step = ALULOADI;
						else if (ireg.fld.aaa[2:1] == 2'b11)
							field_step = CMPI;
					end
					3'b001, 3'b011: begin
						if (ireg.fld.aaa == 3'b001 || ireg.fld.aaa[2])
							field_step = mem_mode(ireg.fld.bbb);
					end
					3'b100: field_step = WBR;
					3'b101: begin
						if (ireg.fld.aaa[2:1] == 2'b10)
							field_step = AZPX;
					end
					3'b111: begin
						if (ireg.fld.aaa == 3'b101)
							field_step = AABX;
					end
					default: field_step = NOP;
				endcase
			end
			default: field_step = NOP;
		endcase
	end

	// irregular opcodes by their full byte
	always_comb begin
		case (ireg.raw)
			8'h00: step0 = BRK;
			8'h40: step0 = RTI;
			8'h60: step0 = RTS;
			8'h4C: step0 = JMPA;
			8'h6C: step0 = JMPI;
			8'h20: step0 = AABSNINC;
			8'h08: step0 = PHP;
			8'h28: step0 = PLP;
			8'h48: step0 = PHA;
			8'h68: step0 = PLA;
			8'h18: step0 = CLC;
			8'h38: step0 = SEC;
			8'h58: step0 = CLI;
			8'h78: step0 = SEI;
			8'hB8: step0 = CLV;
			8'hD8: step0 = CLD;
			8'hF8: step0 = SED;
			8'h8A: step0 = TXA;
			8'h98: step0 = TYA;
			8'h9A: step0 = TXS;
			8'hA8: step0 = TAY;
			8'hAA: step0 = TAX;
			8'hBA: step0 = TSX;
			// accumulator shifts, register inc and dec
			8'h0A, 8'h2A, 8'h4A, 8'h6A,
			8'h88, 8'hC8, 8'hCA, 8'hE8: step0 = ALUOP;
			default: step0 = field_step;
		endcase
	end

endmodule

//--- hdl/op_decoder.sv
`timescale 1ns/10ps

module op_decoder (
	input opdecoder_pkg::opcode_u ireg,
	input logic branch,
	output logic [opdecoder_pkg::STEP_W-1:0] step1,
	output opdecoder_pkg::reg_sel_t reg_sel,
	output opdecoder_pkg::alu_op_t alu_op
);
	import opdecoder_pkg::*;

	// group two alu op by aaa
	function automatic alu_op_t rmw_op(input logic [2:0] aaa);
		alu_op_t op;
		case (aaa)
			3'b000: op = ALU_ASL;
			3'b001: op = ALU_ROL;
			3'b010: op = ALU_LSR;
			3'b011: op = ALU_ROR;
			3'b110: op = ALU_DEC;
			3'b111: op = ALU_INC;
			default: op = ALU_LOAD;
		endcase
		return op;
	endfunction

	always_comb begin
		step1 = NOP;
		reg_sel = REGACC;
		alu_op = ALU_LOAD;
		case (ireg.fld.cc)
			////////////////////////////////////////////////////////////
			// group one, accumulator ops
			////////////////////////////////////////////////////////////
			2'b01: begin
				case (ireg.fld.aaa)
					3'b000: begin
						step1 = ALUOP;
						alu_op = ALU_OR;
					end
					3'b001: begin
						step1 = ALUOP;
						alu_op = ALU_AND;
					end
					3'b010: begin
						step1 = ALUOP;
						alu_op = ALU_EOR;
					end
					3'b011: begin
						step1 = ALUOP;
						alu_op = ALU_ADC;
					end
					3'b100: step1 = ALUMEM;
					3'b101: begin
						step1 = ALULOAD;
						alu_op = ALU_LD;
					end
					3'b110: step1 = CMP;
					default: begin
						step1 = ALUOP;
						alu_op = ALU_SBC;
					end
				endcase
				// immediate finishes in the first step
				if (ireg.fld.bbb == 3'b010)
					step1 = NOP;
			end
			////////////////////////////////////////////////////////////
			// group two, shifts and x moves
			////////////////////////////////////////////////////////////
			2'b10: begin
				case (ireg.fld.bbb)
					3'b001, 3'b011, 3'b101, 3'b111: begin
						case (ireg.fld.aaa)
							3'b100: begin
								if (ireg.fld.bbb != 3'b111) begin
									step1 = ALUMEM;
									reg_sel = REGX;
								end
							end
							3'b101: begin
								step1 = ALULOAD;
								reg_sel = REGX;
								alu_op = ALU_LD;
							end
							default: begin
								step1 = ALUMEM;
								reg_sel = REGDIN;
								alu_op = rmw_op(ireg.fld.aaa);
							end
						endcase
						// ror zero page keeps the accumulator select
						if (ireg.raw == 8'h66)
							reg_sel = REGACC;
					end
					3'b010: begin
						if (!ireg.fld.aaa[2] || ireg.fld.aaa == 3'b110)
							alu_op = rmw_op(ireg.fld.aaa);
						if (ireg.fld.aaa == 3'b110)
							reg_sel = REGX;
					end
					3'b000: begin
						if (ireg.fld.aaa == 3'b101) begin
							reg_sel = REGX;
							alu_op = ALU_LD;
						end
					end
					default: step1 = NOP;
				endcase
			end
			////////////////////////////////////////////////////////////
			// group zero, y and x compare, bit, jsr, branches
			////////////////////////////////////////////////////////////
			2'b00: begin
				case (ireg.fld.bbb)
					3'b100: step1 = branch ? BRA : NBR;
					3'b000: begin
						case (ireg.fld.aaa)
							3'b001: step1 = JSR;
							3'b101: begin
								reg_sel = REGY;
								alu_op = ALU_LD;
							end
							3'b110: reg_sel = REGY;
							3'b111: reg_sel = REGX;
							default: step1 = NOP;
						endcase
					end
					3'b010: begin
						case (ireg.fld.aaa)
							3'b100: begin
								reg_sel = REGY;
								alu_op = ALU_DEC;
							end
							3'b110: begin
								reg_sel = REGY;
								alu_op = ALU_INC;
							end
							3'b111: begin
								reg_sel = REGX;
								alu_op = ALU_INC;
							end
							default: step1 = NOP;
						endcase
					end
					3'b001, 3'b011, 3'b101, 3'b111: begin
						case (ireg.fld.aaa)
							3'b001: begin
								if (!ireg.fld.bbb[2])
									step1 = BIT;
							end
							3'b100: begin
								if (ireg.fld.bbb != 3'b111) begin
									step1 = ALUMEM;
									reg_sel = REGY;
								end
							end
							3'b101: begin
								step1 = ALULOAD;
								reg_sel = REGY;
								alu_op = ALU_LD;
							end
							3'b110: begin
								if (!ireg.fld.bbb[2]) begin
									step1 = CMP;
									reg_sel = REGY;
								end
							end
							3'b111: begin
								if (!ireg.fld.bbb[2]) begin
									step1 = CMP;
									reg_sel = REGX;
								end
							end
							default: step1 = NOP;
						endcase
					end
					default: step1 = NOP;
				endcase
			end
			default: step1 = NOP;
		endcase
	end

endmodule

//--- hdl/opdecoder.sv
`timescale 1ns/10ps

module opdecoder (
	input logic clk,
	input logic rst_n,
	input opdecoder_pkg::opcode_u ireg,
	input logic branch,
	input logic irqen,
	input logic irq_n,
	input logic nmi_n,
	output logic [opdecoder_pkg::ENTRY_W-1:0] step0_a,
	output logic [opdecoder_pkg::ENTRY_W-1:0] step1_a,
	output logic [opdecoder_pkg::ENTRY_W-1:0] int_a,
	output opdecoder_pkg::reg_sel_t register,
	output opdecoder_pkg::alu_op_t alu_op
);
	import opdecoder_pkg::*;

	logic [STEP_W-1:0] step0;
	logic [STEP_W-1:0] step1;
	reg_sel_t reg_sel;
	alu_op_t dec_alu_op;
	decode_t dec;

	mode_decoder mode_decoder_i (
		.ireg  (ireg),
		.step0 (step0)
	);

	op_decoder op_decoder_i (
		.ireg    (ireg),
		.branch  (branch),
		.step1   (step1),
		.reg_sel (reg_sel),
		.alu_op  (dec_alu_op)
	);

	assign dec = '{steps: '{step0: step0, step1: step1}, reg_sel: reg_sel, alu_op: dec_alu_op};

	entry_register entry_register_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.dec      (dec),
		.irq_n    (irq_n),
		.nmi_n    (nmi_n),
		.irqen    (irqen),
		.step0_a  (step0_a),
		.step1_a  (step1_a),
		.int_a    (int_a),
		.register (register),
		.alu_op   (alu_op)
	);

endmodule

//--- hdl/opdecoder_pkg.sv
package opdecoder_pkg;

	localparam int STEP_W = 7;
	localparam int ENTRY_W = 8;

	////////////////////////////////////////////////////////////
	// microcode step numbers
	////////////////////////////////////////////////////////////

	// operation steps
	localparam logic [STEP_W-1:0] ALUOP    = 7'h2D;
	localparam logic [STEP_W-1:0] ALUOPI   = 7'h2E;
	localparam logic [STEP_W-1:0] ALUMEM   = 7'h2F;
	localparam logic [STEP_W-1:0] ALULOAD  = 7'h6D;
	localparam logic [STEP_W-1:0] ALULOADI = 7'h6C;
	localparam logic [STEP_W-1:0] WBR      = 7'h6B;
	localparam logic [STEP_W-1:0] NBR      = 7'h31;
	localparam logic [STEP_W-1:0] BRA      = 7'h32;
	localparam logic [STEP_W-1:0] BIT      = 7'h34;
	localparam logic [STEP_W-1:0] BRK      = 7'h35;
	localparam logic [STEP_W-1:0] CLC      = 7'h3C;
	localparam logic [STEP_W-1:0] CLD      = 7'h3D;
	localparam logic [STEP_W-1:0] CLI      = 7'h3E;
	localparam logic [STEP_W-1:0] CLV      = 7'h3F;
	localparam logic [STEP_W-1:0] CMP      = 7'h40;
	localparam logic [STEP_W-1:0] CMPI     = 7'h41;
	localparam logic [STEP_W-1:0] JMPA     = 7'h42;
	localparam logic [STEP_W-1:0] JMPI     = 7'h45;
	localparam logic [STEP_W-1:0] JSR      = 7'h4C;
	localparam logic [STEP_W-1:0] NOP      = 7'h4F;
	localparam logic [STEP_W-1:0] PHA      = 7'h50;
	localparam logic [STEP_W-1:0] PHP      = 7'h52;
	localparam logic [STEP_W-1:0] PLA      = 7'h54;
	localparam logic [STEP_W-1:0] PLP      = 7'h56;
	localparam logic [STEP_W-1:0] RTI      = 7'h59;
	localparam logic [STEP_W-1:0] RTS      = 7'h5E;
	localparam logic [STEP_W-1:0] SEC      = 7'h62;
	localparam logic [STEP_W-1:0] SED      = 7'h63;
	localparam logic [STEP_W-1:0] SEI      = 7'h64;
	localparam logic [STEP_W-1:0] TAX      = 7'h65;
	localparam logic [STEP_W-1:0] TAY      = 7'h66;
	localparam logic [STEP_W-1:0] TSX      = 7'h67;
	localparam logic [STEP_W-1:0] TXA      = 7'h68;
	localparam logic [STEP_W-1:0] TXS      = 7'h69;
	localparam logic [STEP_W-1:0] TYA      = 7'h6A;

	// addressing steps
	localparam logic [STEP_W-1:0] AABS     = 7'h14;
	localparam logic [STEP_W-1:0] AABSNINC = 7'h6E;
	localparam logic [STEP_W-1:0] AABX     = 7'h17;
	localparam logic [STEP_W-1:0] AABY     = 7'h1A;
	localparam logic [STEP_W-1:0] AZEP     = 7'h1D;
	localparam logic [STEP_W-1:0] AZPX     = 7'h1F;
	localparam logic [STEP_W-1:0] AZPY     = 7'h21;
	localparam logic [STEP_W-1:0] AINX     = 7'h23;
	localparam logic [STEP_W-1:0] AINY     = 7'h28;

	// interrupt and fetch steps
	localparam logic [STEP_W-1:0] IOPC     = 7'h13;
	localparam logic [STEP_W-1:0] IIRQ     = 7'h04;
	localparam logic [STEP_W-1:0] INMI     = 7'h0B;

	////////////////////////////////////////////////////////////
	// register select and alu operation
	////////////////////////////////////////////////////////////

	typedef logic [1:0] reg_sel_t;

	localparam reg_sel_t REGACC = 2'd0;
	localparam reg_sel_t REGX   = 2'd1;
	localparam reg_sel_t REGY   = 2'd2;
	localparam reg_sel_t REGDIN = 2'd3;

	typedef logic [3:0] alu_op_t;

	localparam alu_op_t ALU_LOAD = 4'h0;
	localparam alu_op_t ALU_ADC  = 4'h1;
	localparam alu_op_t ALU_AND  = 4'h2;
	localparam alu_op_t ALU_ASL  = 4'h3;
	localparam alu_op_t ALU_BIT  = 4'h4;
	localparam alu_op_t ALU_CMP  = 4'h5;
	localparam alu_op_t ALU_DEC  = 4'h6;
	localparam alu_op_t ALU_INC  = 4'h7;
	localparam alu_op_t ALU_EOR  = 4'h8;
	localparam alu_op_t ALU_LD   = 4'h9;
	localparam alu_op_t ALU_LSR  = 4'hA;
	localparam alu_op_t ALU_OR   = 4'hB;
	localparam alu_op_t ALU_ROL  = 4'hC;
	localparam alu_op_t ALU_ROR  = 4'hD;
	localparam alu_op_t ALU_SBC  = 4'hE;
	localparam alu_op_t ALU_ISUM = 4'hF;

	// opcode byte, whole or split into aaa/bbb/cc
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [2:0] aaa;
			logic [2:0] bbb;
			logic [1:0] cc;
		} fld;
	} opcode_u;

	typedef struct packed {
		logic [STEP_W-1:0] step0;
		logic [STEP_W-1:0] step1;
	} step_pair_t;

	typedef struct packed {
		step_pair_t steps;
		reg_sel_t reg_sel;
		alu_op_t alu_op;
	} decode_t;

endpackage

//--- project.f
+incdir+dv
hdl/opdecoder_pkg.sv
hdl/mode_decoder.sv
hdl/op_decoder.sv
hdl/entry_register.sv
hdl/opdecoder.sv
dv/opdecoder_assert.sv
dv/tb_opdecoder.sv
